// File: flist.f
mc_harness_pkg.sv
mc_link_if.sv
mc_tag_master.sv
mc_reset_chain.sv
mc_link_router.sv
mc_test_mem.sv
mc_link_tieoff.sv
mc_harness_top.sv
tb_mc_harness.sv

// File: run.sh
#!/bin/sh
# compile the harness testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_mc_harness -f flist.f -o tb_mc_harness \
  && ./obj_dir/tb_mc_harness | tee /dev/stderr | grep -qx 'All tests passed!' \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// File: tb_mc_harness.sv
// testbench for the harness covering tag programming, reset release and link traffic
`timescale 1ns/10ps
`default_nettype none

module tb_mc_harness;

  localparam int WAIT_LIMIT = 100;

  logic                                    clk_i;
  logic                                    arst_n_i;
  logic                                    tag_done_o;
  logic                                    host_req_v_i;
  logic                                    host_req_ready_o;
  mc_harness_pkg::link_op_e                host_req_op_i;
  logic [mc_harness_pkg::X_CORD_WIDTH-1:0] host_req_x_i;
  logic [mc_harness_pkg::ADDR_WIDTH-1:0]   host_req_addr_i;
  logic [mc_harness_pkg::DATA_WIDTH-1:0]   host_req_data_i;
  logic                                    host_rsp_v_o;
  logic                                    host_rsp_ready_i;
  mc_harness_pkg::link_rsp_e               host_rsp_type_o;
  logic [mc_harness_pkg::TAG_WIDTH-1:0]    host_rsp_src_o;
  logic [mc_harness_pkg::DATA_WIDTH-1:0]   host_rsp_data_o;

  int errors;
  int errors_at_start;
  int tests_run;
  int tests_failed;
  int reqs_sent = 0;
  int rsps_seen = 0;

  logic [mc_harness_pkg::DATA_WIDTH-1:0] mem_model [mc_harness_pkg::MEM_DEPTH];
  logic [mc_harness_pkg::ADDR_WIDTH-1:0] written_addrs [$];

  mc_harness_top i_mc_harness_top (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .tag_done_o       (tag_done_o),
    .host_req_v_i     (host_req_v_i),
    .host_req_ready_o (host_req_ready_o),
    .host_req_op_i    (host_req_op_i),
    .host_req_x_i     (host_req_x_i),
    .host_req_addr_i  (host_req_addr_i),
    .host_req_data_i  (host_req_data_i),
    .host_rsp_v_o     (host_rsp_v_o),
    .host_rsp_ready_i (host_rsp_ready_i),
    .host_rsp_type_o  (host_rsp_type_o),
    .host_rsp_src_o   (host_rsp_src_o),
    .host_rsp_data_o  (host_rsp_data_o)
  );

  always #10 clk_i = ~clk_i;

  // handshakes as they happen on the host link
  always @(posedge clk_i) begin
    if (arst_n_i && host_req_v_i && host_req_ready_o) begin
      reqs_sent++;
    end
    if (arst_n_i && host_rsp_v_o && host_rsp_ready_i) begin
      rsps_seen++;
    end
  end

  // stalled response keeps valid and payload
  rsp_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rsp_v_o && !host_rsp_ready_i |=> host_rsp_v_o && $stable(host_rsp_type_o)
      && $stable(host_rsp_src_o) && $stable(host_rsp_data_o))
  else begin
    errors++;
    $display("ERROR @%0t: response changed or dropped under back-pressure", $time);
  end

  // source id and data shape follow the response type
  rsp_fields_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rsp_v_o |-> ((host_rsp_type_o inside {mc_harness_pkg::RSP_READ_DATA,
      mc_harness_pkg::RSP_WRITE_ACK} && host_rsp_src_o == mc_harness_pkg::MEM_NODE_ID)
      || (host_rsp_type_o == mc_harness_pkg::RSP_ERROR
      && host_rsp_src_o == mc_harness_pkg::TIEOFF_NODE_ID
      && host_rsp_data_o[mc_harness_pkg::DATA_WIDTH-1:mc_harness_pkg::ADDR_WIDTH] == '0)))
  else begin
    errors++;
    $display("ERROR @%0t: response fields inconsistent with type", $time);
  end

  done_sticky_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tag_done_o |=> tag_done_o)
  else begin
    errors++;
    $display("ERROR @%0t: tag done dropped", $time);
  end

  no_ready_in_tag_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !tag_done_o |-> !host_req_ready_o)
  else begin
    errors++;
    $display("ERROR @%0t: host ready before tag programming finished", $time);
  end

  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("ERROR @%0t: %s got %0h expected %0h", $time, what, got, exp);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic close_test(input int num, input string name);
    tests_run++;
    if (errors > errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: FAIL", num, name);
    end else begin
      $display("test %0d %s: PASS", num, name);
    end
    errors_at_start = errors;
  endtask

  task automatic send_req(input mc_harness_pkg::link_op_e op,
                          input logic [mc_harness_pkg::X_CORD_WIDTH-1:0] x,
                          input logic [mc_harness_pkg::ADDR_WIDTH-1:0] addr,
                          input logic [mc_harness_pkg::DATA_WIDTH-1:0] data);
    int  waited;
    bit  taken;
    waited          = 0;
    taken           = 1'b0;
    host_req_v_i    = 1'b1;
    host_req_op_i   = op;
    host_req_x_i    = x;
    host_req_addr_i = addr;
    host_req_data_i = data;
    while (!taken) begin
      @(negedge clk_i);
      taken = host_req_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
      if (!taken && waited >= WAIT_LIMIT) stop_on_timeout("request acceptance");
    end
    host_req_v_i = 1'b0;
  endtask

  task automatic recv_rsp(input int stall, output mc_harness_pkg::link_rsp_e rtype,
                          output logic [mc_harness_pkg::TAG_WIDTH-1:0] src,
                          output logic [mc_harness_pkg::DATA_WIDTH-1:0] data);
    int waited;
    int held;
    bit got;
    waited           = 0;
    held             = 0;
    got              = 1'b0;
    host_rsp_ready_i = (stall == 0);
    while (!got) begin
      @(negedge clk_i);
      if (host_rsp_v_o && host_rsp_ready_i) begin
        rtype = host_rsp_type_o;
        src   = host_rsp_src_o;
        data  = host_rsp_data_o;
        got   = 1'b1;
      end else if (host_rsp_v_o) begin
        held++;
        assert (!host_req_ready_o) else begin
          errors++;
          $display("ERROR @%0t: endpoint ready while its response is pending", $time);
        end
      end
      @(posedge clk_i);
      #1;
      waited++;
      if (held >= stall) host_rsp_ready_i = 1'b1;
      if (!got && waited >= WAIT_LIMIT) stop_on_timeout("a response");
    end
    // a consumed response must not show up again
    @(negedge clk_i);
    assert (!host_rsp_v_o) else begin
      errors++;
      $display("ERROR @%0t: response still valid after it was taken", $time);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic do_transfer(input mc_harness_pkg::link_op_e op,
                             input logic [mc_harness_pkg::X_CORD_WIDTH-1:0] x,
                             input logic [mc_harness_pkg::ADDR_WIDTH-1:0] addr,
                             input logic [mc_harness_pkg::DATA_WIDTH-1:0] data,
                             input int stall);
    mc_harness_pkg::link_rsp_e             exp_type;
    logic [mc_harness_pkg::TAG_WIDTH-1:0]  exp_src;
    logic [mc_harness_pkg::DATA_WIDTH-1:0] exp_data;
    mc_harness_pkg::link_rsp_e             got_type;
    logic [mc_harness_pkg::TAG_WIDTH-1:0]  got_src;
    logic [mc_harness_pkg::DATA_WIDTH-1:0] got_data;
    if (x == mc_harness_pkg::MEM_X_CORD) begin
      exp_src = mc_harness_pkg::MEM_NODE_ID;
      if (op == mc_harness_pkg::OP_WRITE) begin
        exp_type        = mc_harness_pkg::RSP_WRITE_ACK;
        exp_data        = data;
        mem_model[addr] = data;
        written_addrs.push_back(addr);
      end else begin
        exp_type = mc_harness_pkg::RSP_READ_DATA;
        exp_data = mem_model[addr];
      end
    end else begin
      exp_type = mc_harness_pkg::RSP_ERROR;
      exp_src  = mc_harness_pkg::TIEOFF_NODE_ID;
      exp_data = 32'(addr);
    end
    send_req(op, x, addr, data);
    recv_rsp(stall, got_type, got_src, got_data);
    assert (got_type === exp_type)
      else flag_mismatch("response type", 32'(got_type), 32'(exp_type));
    assert (got_src === exp_src)
      else flag_mismatch("response source", 32'(got_src), 32'(exp_src));
    assert (got_data === exp_data)
      else flag_mismatch("response data", got_data, exp_data);
  endtask

  // memory or tieoff at random, reads only hit written words
  task automatic random_transfer(input int stall);
    logic [mc_harness_pkg::X_CORD_WIDTH-1:0] x;
    logic [mc_harness_pkg::ADDR_WIDTH-1:0]   addr;
    mc_harness_pkg::link_op_e                op;
    x    = ($urandom_range(0, 1) == 0) ? mc_harness_pkg::MEM_X_CORD : 4'($urandom_range(1, 15));
    addr = 8'($urandom());
    op   = ($urandom_range(0, 1) == 0) ? mc_harness_pkg::OP_READ : mc_harness_pkg::OP_WRITE;
    if (x == mc_harness_pkg::MEM_X_CORD && op == mc_harness_pkg::OP_READ) begin
      if (written_addrs.size() == 0) begin
        op = mc_harness_pkg::OP_WRITE;
      end else begin
        addr = written_addrs[$urandom_range(0, written_addrs.size() - 1)];
      end
    end
    do_transfer(op, x, addr, $urandom(), stall);
  endtask

  initial begin
    int cycles;
    int sent_before;
    int seen_before;
    int num_writes;
    errors           = 0;
    errors_at_start  = 0;
    tests_run        = 0;
    tests_failed     = 0;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    host_req_v_i     = 1'b0;
    host_req_op_i    = mc_harness_pkg::OP_READ;
    host_req_x_i     = mc_harness_pkg::MEM_X_CORD;
    host_req_addr_i  = '0;
    host_req_data_i  = '0;
    host_rsp_ready_i = 1'b0;
    void'($urandom(32'heb4b));

    // test 1 tag programming then reset release
    repeat (16) @(posedge clk_i);
    #1;
    assert (!tag_done_o && !host_req_ready_o && !host_rsp_v_o) else begin
      errors++;
      $display("ERROR @%0t: outputs not low during reset", $time);
    end
    arst_n_i = 1'b1;
    cycles   = 0;
    while (!tag_done_o) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles >= WAIT_LIMIT) stop_on_timeout("tag done");
    end
    assert (cycles == mc_harness_pkg::TAG_CYCLES)
      else flag_mismatch("tag done delay", 32'(cycles), 32'(mc_harness_pkg::TAG_CYCLES));
    cycles = 0;
    while (!host_req_ready_o) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles >= WAIT_LIMIT) stop_on_timeout("host ready");
    end
    assert (cycles == mc_harness_pkg::RESET_DEPTH)
      else flag_mismatch("core reset delay", 32'(cycles), 32'(mc_harness_pkg::RESET_DEPTH));
    close_test(1, "tag and reset sequencing");

    // test 2 writes then reads of the same words
    for (int i = 0; i < 12; i++) begin
      do_transfer(mc_harness_pkg::OP_WRITE, mc_harness_pkg::MEM_X_CORD, 8'($urandom()),
                  $urandom(), 0);
    end
    num_writes = written_addrs.size();
    for (int i = 0; i < num_writes; i++) begin
      do_transfer(mc_harness_pkg::OP_READ, mc_harness_pkg::MEM_X_CORD, written_addrs[i],
                  '0, 0);
    end
    close_test(2, "memory write and read");

    // test 3 every other column hits the tieoff
    for (int i = 0; i < 10; i++) begin
      do_transfer(($urandom_range(0, 1) == 0) ? mc_harness_pkg::OP_READ : mc_harness_pkg::OP_WRITE,
                  4'($urandom_range(1, 15)), 8'($urandom()), $urandom(), 0);
    end
    close_test(3, "tieoff error responses");

    // test 4 back-pressure on the host response
    sent_before = reqs_sent;
    seen_before = rsps_seen;
    for (int i = 0; i < 12; i++) begin
      random_transfer($urandom_range(1, 6));
    end
    // one bus response per accepted request
    assert (rsps_seen - seen_before == reqs_sent - sent_before)
      else flag_mismatch("response count", 32'(rsps_seen - seen_before),
                         32'(reqs_sent - sent_before));
    close_test(4, "response back-pressure");

    // test 5 interleaved traffic, checked in issue order
    for (int i = 0; i < 20; i++) begin
      random_transfer(0);
    end
    close_test(5, "mixed traffic");

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mc_harness_top.sv
// harness top with tag master, reset chain, host router and link endpoints
`timescale 1ns/10ps
`default_nettype none

module mc_harness_top (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  output logic                                    tag_done_o,

  input  logic                                    host_req_v_i,
  output logic                                    host_req_ready_o,
  input  mc_harness_pkg::link_op_e                host_req_op_i,
  input  logic [mc_harness_pkg::X_CORD_WIDTH-1:0] host_req_x_i,
  input  logic [mc_harness_pkg::ADDR_WIDTH-1:0]   host_req_addr_i,
  input  logic [mc_harness_pkg::DATA_WIDTH-1:0]   host_req_data_i,

  output logic                                    host_rsp_v_o,
  input  logic                                    host_rsp_ready_i,
  output mc_harness_pkg::link_rsp_e               host_rsp_type_o,
  output logic [mc_harness_pkg::TAG_WIDTH-1:0]    host_rsp_src_o,
  output logic [mc_harness_pkg::DATA_WIDTH-1:0]   host_rsp_data_o
);

  logic                                       tag_done;
  logic [mc_harness_pkg::NUM_TAG_CLIENTS-1:0] tag_en;
  logic                                       tag_bit;
  logic                                       core_reset;
  mc_harness_pkg::link_req_s                  host_req;
  mc_harness_pkg::link_rsp_s                  host_rsp;

  mc_link_if mem_link ();
  mc_link_if tieoff_link ();

  assign host_req.op     = host_req_op_i;
  assign host_req.x_cord = host_req_x_i;
  assign host_req.addr   = host_req_addr_i;
  assign host_req.data   = host_req_data_i;

  assign host_rsp_type_o = host_rsp.rsp_type;
  assign host_rsp_src_o  = host_rsp.src_id;
  assign host_rsp_data_o = host_rsp.data;
  assign tag_done_o      = tag_done;

  mc_tag_master i_mc_tag_master (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tag_en_o   (tag_en),
    .tag_bit_o  (tag_bit),
    .tag_done_o (tag_done)
  );

  mc_reset_chain i_mc_reset_chain (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tag_done_i   (tag_done),
    .core_reset_o (core_reset)
  );

  mc_link_router i_mc_link_router (
    .core_reset_i     (core_reset),
    .host_req_v_i     (host_req_v_i),
    .host_req_ready_o (host_req_ready_o),
    .host_req_i       (host_req),
    .host_rsp_v_o     (host_rsp_v_o),
    .host_rsp_ready_i (host_rsp_ready_i),
    .host_rsp_o       (host_rsp),
    .mem_link         (mem_link.router),
    .tieoff_link      (tieoff_link.router)
  );

  mc_test_mem i_mc_test_mem (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .core_reset_i (core_reset),
    .tag_en_i     (tag_en[mc_harness_pkg::MEM_TAG_IDX]),
    .tag_bit_i    (tag_bit),
    .link         (mem_link.endpoint)
  );

  mc_link_tieoff i_mc_link_tieoff (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .core_reset_i (core_reset),
    .tag_en_i     (tag_en[mc_harness_pkg::TIEOFF_TAG_IDX]),
    .tag_bit_i    (tag_bit),
    .link         (tieoff_link.endpoint)
  );

endmodule

`default_nettype wire

// File: mc_link_tieoff.sv
// link tieoff endpoint that answers every request with an error response
`timescale 1ns/10ps
`default_nettype none

module mc_link_tieoff (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        core_reset_i,
  input  logic        tag_en_i,
  input  logic        tag_bit_i,
  mc_link_if.endpoint link
);

  localparam int PAD_WIDTH = mc_harness_pkg::DATA_WIDTH - mc_harness_pkg::ADDR_WIDTH;

  logic [mc_harness_pkg::TAG_WIDTH-1:0] node_id_r;
  logic                                 rsp_v_r;
  mc_harness_pkg::link_rsp_s            rsp_r;
  logic                                 req_fire;

  assign link.req_ready = ~rsp_v_r;
  assign req_fire       = link.req_v & ~rsp_v_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      node_id_r <= '0;
    end else if (tag_en_i) begin
      node_id_r <= {node_id_r[mc_harness_pkg::TAG_WIDTH-2:0], tag_bit_i};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_v_r <= 1'b0;
    end else if (core_reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (req_fire) begin
      rsp_v_r <= 1'b1;
    end else if (link.rsp_ready) begin
      rsp_v_r <= 1'b0;
    end
  end

  // error carries the offending address
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_r.rsp_type <= mc_harness_pkg::RSP_ERROR;
      rsp_r.src_id   <= node_id_r;
      rsp_r.data     <= {{PAD_WIDTH{1'b0}}, link.req.addr};
    end
  end

  assign link.rsp_v = rsp_v_r;
  assign link.rsp   = rsp_r;

endmodule

`default_nettype wire

// File: mc_test_mem.sv
// test memory endpoint that answers word reads and writes on the link
`timescale 1ns/10ps
`default_nettype none

module mc_test_mem (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        core_reset_i,
  input  logic        tag_en_i,
  input  logic        tag_bit_i,
  mc_link_if.endpoint link
);

  logic [mc_harness_pkg::DATA_WIDTH-1:0] mem_r [mc_harness_pkg::MEM_DEPTH];
  logic [mc_harness_pkg::TAG_WIDTH-1:0]  node_id_r;
  logic                                  rsp_v_r;
  mc_harness_pkg::link_rsp_s             rsp_r;
  logic                                  req_fire;
  logic                                  rsp_fire;
  logic                                  is_write;

  // one request in flight at a time
  assign link.req_ready = ~rsp_v_r;
  assign req_fire       = link.req_v & ~rsp_v_r;
  assign rsp_fire       = rsp_v_r & link.rsp_ready;
  assign is_write       = (link.req.op == mc_harness_pkg::OP_WRITE);

  // node id shifts in msb first from the tag master
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      node_id_r <= '0;
    end else if (tag_en_i) begin
      node_id_r <= {node_id_r[mc_harness_pkg::TAG_WIDTH-2:0], tag_bit_i};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_v_r <= 1'b0;
    end else if (core_reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (req_fire) begin
      rsp_v_r <= 1'b1;
    end else if (rsp_fire) begin
      rsp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && is_write) begin
      mem_r[link.req.addr] <= link.req.data;
    end
  end

  // response is captured at acceptance and held under back-pressure
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_r.src_id <= node_id_r;
      if (is_write) begin
        rsp_r.rsp_type <= mc_harness_pkg::RSP_WRITE_ACK;
        rsp_r.data     <= link.req.data;
      end else begin
        rsp_r.rsp_type <= mc_harness_pkg::RSP_READ_DATA;
        rsp_r.data     <= mem_r[link.req.addr];
      end
    end
  end

  assign link.rsp_v = rsp_v_r;
  assign link.rsp   = rsp_r;

endmodule

`default_nettype wire

// File: mc_link_router.sv
// host link router that steers requests by x coordinate and merges responses
`timescale 1ns/10ps
`default_nettype none

module mc_link_router (
  input  logic                      core_reset_i,

  input  logic                      host_req_v_i,
  output logic                      host_req_ready_o,
  input  mc_harness_pkg::link_req_s host_req_i,

  output logic                      host_rsp_v_o,
  input  logic                      host_rsp_ready_i,
  output mc_harness_pkg::link_rsp_s host_rsp_o,

  mc_link_if.router                 mem_link,
  mc_link_if.router                 tieoff_link
);

  logic sel_mem;
  logic host_req_v;
  logic dst_ready;

  assign sel_mem = (host_req_i.x_cord == mc_harness_pkg::MEM_X_CORD);

  // nothing enters the endpoints while the core is held in reset
  assign host_req_v = host_req_v_i & ~core_reset_i;

  assign mem_link.req_v    = host_req_v & sel_mem;
  assign mem_link.req      = host_req_i;
  assign tieoff_link.req_v = host_req_v & ~sel_mem;
  assign tieoff_link.req   = host_req_i;

  assign dst_ready        = sel_mem ? mem_link.req_ready : tieoff_link.req_ready;
  assign host_req_ready_o = dst_ready & ~core_reset_i;

  // fixed priority, memory ahead of tieoff
  always_comb begin
    if (mem_link.rsp_v) begin
      host_rsp_o = mem_link.rsp;
    end else begin
      host_rsp_o = tieoff_link.rsp;
    end
  end

  assign host_rsp_v_o          = mem_link.rsp_v | tieoff_link.rsp_v;
  assign mem_link.rsp_ready    = host_rsp_ready_i;
  assign tieoff_link.rsp_ready = host_rsp_ready_i & ~mem_link.rsp_v;

endmodule

`default_nettype wire

// File: mc_reset_chain.sv
// reset chain that releases core reset a fixed depth after tag programming ends
`timescale 1ns/10ps
`default_nettype none

module mc_reset_chain (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic tag_done_i,
  output logic core_reset_o
);

  logic [mc_harness_pkg::RESET_DEPTH-1:0] chain_r;

  // set on async reset, drains once tag done is seen
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      chain_r <= '1;
    end else begin
      chain_r <= {chain_r[mc_harness_pkg::RESET_DEPTH-2:0], ~tag_done_i};
    end
  end

  assign core_reset_o = chain_r[mc_harness_pkg::RESET_DEPTH-1];

endmodule

`default_nettype wire

// File: mc_tag_master.sv
// tag master that shifts node identifiers into the link endpoints after reset
`timescale 1ns/10ps
`default_nettype none

module mc_tag_master (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  output logic [mc_harness_pkg::NUM_TAG_CLIENTS-1:0] tag_en_o,
  output logic                                       tag_bit_o,
  output logic                                       tag_done_o
);

  logic [mc_harness_pkg::TAG_CNT_WIDTH-1:0] cnt_r;
  logic                                     done_r;
  logic [mc_harness_pkg::TAG_SEL_WIDTH-1:0] client_sel;
  logic [mc_harness_pkg::TAG_BIT_WIDTH-1:0] bit_sel;
  logic [mc_harness_pkg::TAG_WIDTH-1:0]     cur_id;

  // one shift per cycle until every client has its identifier
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r  <= '0;
      done_r <= 1'b0;
    end else if (!done_r) begin
      cnt_r <= cnt_r + 1'b1;
      if (cnt_r == mc_harness_pkg::TAG_CYCLES - 1) begin
        done_r <= 1'b1;
      end
    end
  end

  // upper counter bits pick the client, lower bits the bit slot
  assign client_sel = cnt_r[mc_harness_pkg::TAG_CNT_WIDTH-1 -: mc_harness_pkg::TAG_SEL_WIDTH];
  assign bit_sel    = cnt_r[mc_harness_pkg::TAG_BIT_WIDTH-1:0];
  assign cur_id     = mc_harness_pkg::TAG_NODE_IDS[client_sel];

  // msb goes out first
  assign tag_bit_o = cur_id[mc_harness_pkg::TAG_WIDTH - 1 - bit_sel];

  always_comb begin
    for (int i = 0; i < mc_harness_pkg::NUM_TAG_CLIENTS; i++) begin
      tag_en_o[i] = !done_r && (client_sel == i);
    end
  end

  assign tag_done_o = done_r;

endmodule

`default_nettype wire

// File: mc_link_if.sv
// request/response link between the host router and one endpoint
`timescale 1ns/10ps
`default_nettype none

interface mc_link_if;

  logic                      req_v;
  logic                      req_ready;
  mc_harness_pkg::link_req_s req;

  logic                      rsp_v;
  logic                      rsp_ready;
  mc_harness_pkg::link_rsp_s rsp;

  modport router (
    output req_v, req, rsp_ready,
    input  req_ready, rsp_v, rsp
  );

  modport endpoint (
    input  req_v, req, rsp_ready,
    output req_ready, rsp_v, rsp
  );

endinterface

`default_nettype wire

// File: mc_harness_pkg.sv
// harness package with link constants, opcodes and packet formats
`default_nettype none

package mc_harness_pkg;

  // link geometry
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int X_CORD_WIDTH = 4;

  // x coordinate of the memory column
  localparam logic [X_CORD_WIDTH-1:0] MEM_X_CORD = 4'd0;
  localparam int MEM_DEPTH = 256;

  // tag programming
  localparam int TAG_WIDTH = 8;
  localparam int NUM_TAG_CLIENTS = 2;
  localparam int TAG_CYCLES = TAG_WIDTH * NUM_TAG_CLIENTS;
  localparam int TAG_CNT_WIDTH = $clog2(TAG_CYCLES);
  localparam int TAG_SEL_WIDTH = $clog2(NUM_TAG_CLIENTS);
  localparam int TAG_BIT_WIDTH = $clog2(TAG_WIDTH);

  localparam logic [TAG_WIDTH-1:0] MEM_NODE_ID = 8'h5a;
  localparam logic [TAG_WIDTH-1:0] TIEOFF_NODE_ID = 8'hc3;

  // client slots, programmed from index 0 upwards
  localparam int MEM_TAG_IDX = 0;
  localparam int TIEOFF_TAG_IDX = 1;
  localparam logic [NUM_TAG_CLIENTS-1:0][TAG_WIDTH-1:0] TAG_NODE_IDS = {
    TIEOFF_NODE_ID,
    MEM_NODE_ID
  };

  // cycles from tag done to core reset release
  localparam int RESET_DEPTH = 3;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } link_op_e;

  typedef enum logic [1:0] {
    RSP_READ_DATA,
    RSP_WRITE_ACK,
    RSP_ERROR
  } link_rsp_e;

  typedef struct packed {
    link_op_e                op;
    logic [X_CORD_WIDTH-1:0] x_cord;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
  } link_req_s;

  typedef struct packed {
    link_rsp_e             rsp_type;
    logic [TAG_WIDTH-1:0]  src_id;
    logic [DATA_WIDTH-1:0] data;
  } link_rsp_s;

endpackage

`default_nettype wire
